//--- include/md_macros.svh
// Multiply/divide unit sizing macros
// Word width, half-word width and the division step count

`ifndef MD_MACROS_SVH
`define MD_MACROS_SVH

// Operand and result width
`define MD_XLEN 32

// Partial product operand width
`define MD_HALF 16

// One restoring step per quotient bit
`define MD_DIV_STEPS 32

// Wide enough to index every dividend bit
`define MD_CNT_W 5

`endif

//--- hw/md_pkg.sv
// Multiply/divide unit types
// Word, half-word and counter types plus the operation and FSM encodings

`include "md_macros.svh"

package md_pkg;

  typedef logic [`MD_XLEN-1:0]  md_word_t;
  typedef logic [`MD_HALF-1:0]  md_half_t;
  // Two extra bits keep sign and carry of the running sum
  typedef logic [`MD_XLEN+1:0]  md_acc_t;
  typedef logic [`MD_CNT_W-1:0] md_cnt_t;
  // Bit 0 marks operand a as signed, bit 1 operand b
  typedef logic [1:0]           md_sign_t;

  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Named after the operand halves multiplied in each step
  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } md_mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN,
    DIV_ZERO
  } md_div_state_e;

endpackage

//--- hw/md_decode.sv
// Multiply/divide request decode
// Captures an accepted request and launches the multiplier or the divider

`timescale 1ns/10ps

module md_decode (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  logic             busy_i,
  input  md_pkg::md_op_e   op_i,
  input  md_pkg::md_sign_t sign_mode_i,
  input  md_pkg::md_word_t op_a_i,
  input  md_pkg::md_word_t op_b_i,
  output md_pkg::md_op_e   op_o,
  output md_pkg::md_sign_t sign_mode_o,
  output md_pkg::md_word_t op_a_o,
  output md_pkg::md_word_t op_b_o,
  output logic             mult_go_o,
  output logic             div_go_o
);

  import md_pkg::*;

  logic     accept;
  logic     is_div;
  logic     mult_go_q;
  logic     div_go_q;
  md_op_e   op_q;
  md_sign_t sign_mode_q;
  md_word_t op_a_q;
  md_word_t op_b_q;

  // Requests arriving while busy are dropped
  assign accept = start_i & ~busy_i;
  assign is_div = (op_i == MD_OP_DIV) || (op_i == MD_OP_REM);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mult_go_q <= 1'b0;
      div_go_q  <= 1'b0;
    end else begin
      mult_go_q <= accept & ~is_div;
      div_go_q  <= accept & is_div;
    end
  end

  // Held stable for the whole operation
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q        <= op_i;
      sign_mode_q <= sign_mode_i;
      op_a_q      <= op_a_i;
      op_b_q      <= op_b_i;
    end
  end

  assign op_o        = op_q;
  assign sign_mode_o = sign_mode_q;
  assign op_a_o      = op_a_q;
  assign op_b_o      = op_b_q;
  assign mult_go_o   = mult_go_q;
  assign div_go_o    = div_go_q;

endmodule

//--- hw/md_mult.sv
// Fast multiplier
// One 17x17 signed multiply-accumulate stepped over the four half-word
// partial products, three steps for MUL and four for MULH

`timescale 1ns/10ps

`include "md_macros.svh"

module md_mult (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             go_i,
  input  md_pkg::md_op_e   op_i,
  input  md_pkg::md_sign_t sign_mode_i,
  input  md_pkg::md_word_t op_a_i,
  input  md_pkg::md_word_t op_b_i,
  output logic             done_o,
  output md_pkg::md_word_t result_o
);

  import md_pkg::*;

  md_mult_state_e state_q, state_d;
  md_half_t       mult_op_a;
  md_half_t       mult_op_b;
  logic           sign_a;
  logic           sign_b;
  logic           signed_mult;
  md_acc_t        accum;
  md_acc_t        mac_res;
  md_acc_t        acc_q, acc_d;
  logic           active_q;
  logic           done_q;
  logic           last_step;

  assign signed_mult = |sign_mode_i;

  // Top two bits of the 35-bit sum always match, so 34 bits are enough
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b})
                 + $signed(accum);

  always_comb begin
    mult_op_a = op_a_i[`MD_HALF-1:0];
    mult_op_b = op_b_i[`MD_HALF-1:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = '0;
    acc_d     = mac_res;
    state_d   = state_q;
    last_step = 1'b0;

    unique case (state_q)
      ALBL: begin
        state_d = ALBH;
      end
      ALBH: begin
        mult_op_b = op_b_i[`MD_XLEN-1:`MD_HALF];
        sign_b    = sign_mode_i[1] & op_b_i[`MD_XLEN-1];
        // al*bl is unsigned with no carry out
        accum     = {{(`MD_HALF+2){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
        if (op_i == MD_OP_MULL) begin
          acc_d = {2'b00, mac_res[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
        end
        state_d = AHBL;
      end
      AHBL: begin
        mult_op_a = op_a_i[`MD_XLEN-1:`MD_HALF];
        sign_a    = sign_mode_i[0] & op_a_i[`MD_XLEN-1];
        if (op_i == MD_OP_MULL) begin
          accum     = {{(`MD_HALF+2){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
          acc_d     = {2'b00, mac_res[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
          last_step = 1'b1;
          state_d   = ALBL;
        end else begin
          accum   = acc_q;
          state_d = AHBH;
        end
      end
      AHBH: begin
        mult_op_a = op_a_i[`MD_XLEN-1:`MD_HALF];
        mult_op_b = op_b_i[`MD_XLEN-1:`MD_HALF];
        sign_a    = sign_mode_i[0] & op_a_i[`MD_XLEN-1];
        sign_b    = sign_mode_i[1] & op_b_i[`MD_XLEN-1];
        // Middle sum is unsigned only when both operands are
        accum     = {{`MD_HALF{signed_mult & acc_q[`MD_XLEN+1]}},
                     acc_q[`MD_XLEN+1:`MD_HALF]};
        last_step = 1'b1;
        state_d   = ALBL;
      end
      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= ALBL;
      active_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= active_q & last_step;
      if (go_i) begin
        active_q <= 1'b1;
      end else if (active_q & last_step) begin
        active_q <= 1'b0;
      end
      if (active_q) begin
        state_q <= state_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (active_q) begin
      acc_q <= acc_d;
    end
  end

  assign done_o   = done_q;
  assign result_o = acc_q[`MD_XLEN-1:0];

endmodule

//--- hw/md_div.sv
// Long divider
// Restoring division on absolute values with a final sign fix-up,
// a zero divisor skips straight to the architectural result

`timescale 1ns/10ps

`include "md_macros.svh"

module md_div (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             go_i,
  input  md_pkg::md_op_e   op_i,
  input  md_pkg::md_sign_t sign_mode_i,
  input  md_pkg::md_word_t op_a_i,
  input  md_pkg::md_word_t op_b_i,
  output logic             done_o,
  output md_pkg::md_word_t result_o
);

  import md_pkg::*;

  md_div_state_e     state_q, state_d;
  md_cnt_t           cnt_q, cnt_d;
  md_word_t          numer_q, numer_d;
  md_word_t          denom_q, denom_d;
  md_word_t          quot_q, quot_d;
  md_word_t          rem_q, rem_d;
  md_word_t          res_q, res_d;
  logic              done_q, done_d;
  logic [`MD_XLEN:0] sub_a;
  logic [`MD_XLEN:0] sub_b;
  logic [`MD_XLEN:0] sub_res;
  logic [`MD_XLEN:0] rem_shift;
  logic              ge;
  md_word_t          one_shift;
  md_word_t          next_quot;
  md_word_t          next_rem;
  md_word_t          sign_val;
  logic              sign_a;
  logic              sign_b;
  logic              is_div;
  logic              negate;

  assign sign_a = sign_mode_i[0] & op_a_i[`MD_XLEN-1];
  assign sign_b = sign_mode_i[1] & op_b_i[`MD_XLEN-1];
  assign is_div = (op_i == MD_OP_DIV);

  // Private subtractor, shared by abs, compare and sign steps
  assign sub_res = sub_a - sub_b;

  // Partial remainder stays below the divisor, so the shifted value minus
  // the divisor always fits in 33 signed bits
  assign rem_shift = {rem_q, numer_q[cnt_q]};
  assign ge        = ~sub_res[`MD_XLEN];
  assign one_shift = md_word_t'(1) << cnt_q;
  assign next_quot = ge ? (quot_q | one_shift) : quot_q;
  assign next_rem  = ge ? sub_res[`MD_XLEN-1:0] : rem_shift[`MD_XLEN-1:0];

  // Remainder follows the dividend sign
  assign sign_val = is_div ? quot_q : rem_q;
  assign negate   = is_div ? (sign_a ^ sign_b) : sign_a;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    numer_d = numer_q;
    denom_d = denom_q;
    quot_d  = quot_q;
    rem_d   = rem_q;
    res_d   = res_q;
    done_d  = 1'b0;
    sub_a   = '0;
    sub_b   = {1'b0, op_b_i};

    unique case (state_q)
      DIV_IDLE: begin
        if (go_i) begin
          state_d = (op_b_i == '0) ? DIV_ZERO : DIV_ABS_A;
        end
      end
      DIV_ABS_A: begin
        sub_b   = {1'b0, op_a_i};
        numer_d = sign_a ? sub_res[`MD_XLEN-1:0] : op_a_i;
        state_d = DIV_ABS_B;
      end
      DIV_ABS_B: begin
        denom_d = sign_b ? sub_res[`MD_XLEN-1:0] : op_b_i;
        quot_d  = '0;
        rem_d   = '0;
        cnt_d   = md_cnt_t'(`MD_DIV_STEPS - 1);
        state_d = DIV_COMP;
      end
      DIV_COMP: begin
        sub_a  = rem_shift;
        sub_b  = {1'b0, denom_q};
        rem_d  = next_rem;
        quot_d = next_quot;
        cnt_d  = cnt_q - 1'b1;
        if (cnt_q == md_cnt_t'(1)) begin
          state_d = DIV_LAST;
        end
      end
      DIV_LAST: begin
        // Step for bit 0
        sub_a   = rem_shift;
        sub_b   = {1'b0, denom_q};
        rem_d   = next_rem;
        quot_d  = next_quot;
        state_d = DIV_SIGN;
      end
      DIV_SIGN: begin
        sub_b   = {1'b0, sign_val};
        res_d   = negate ? sub_res[`MD_XLEN-1:0] : sign_val;
        done_d  = 1'b1;
        state_d = DIV_IDLE;
      end
      DIV_ZERO: begin
        res_d   = is_div ? '1 : op_a_i;
        done_d  = 1'b1;
        state_d = DIV_IDLE;
      end
      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    numer_q <= numer_d;
    denom_q <= denom_d;
    quot_q  <= quot_d;
    rem_q   <= rem_d;
    res_q   <= res_d;
  end

  assign done_o   = done_q;
  assign result_o = res_q;

endmodule

//--- hw/md_result.sv
// Multiply/divide result stage
// Captures the finishing unit's word, strobes valid and tracks busy

`timescale 1ns/10ps

module md_result (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             accept_i,
  input  logic             mult_done_i,
  input  logic             div_done_i,
  input  md_pkg::md_word_t mult_res_i,
  input  md_pkg::md_word_t div_res_i,
  output logic             valid_o,
  output logic             busy_o,
  output md_pkg::md_word_t result_o
);

  import md_pkg::*;

  logic     valid_q;
  logic     busy_q;
  md_word_t result_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      busy_q   <= 1'b0;
      result_q <= '0;
    end else begin
      valid_q <= mult_done_i | div_done_i;
      if (mult_done_i) begin
        result_q <= mult_res_i;
      end else if (div_done_i) begin
        result_q <= div_res_i;
      end
      // Busy drops together with the valid strobe
      if (accept_i) begin
        busy_q <= 1'b1;
      end else if (valid_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Launch cycle already counts as busy
  assign busy_o   = busy_q | accept_i;
  assign valid_o  = valid_q;
  assign result_o = result_q;

endmodule

//--- hw/md_top.sv
// Multiply/divide unit top level
// Decode, fast multiplier, long divider and result stage

`timescale 1ns/10ps

module md_top (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  md_pkg::md_op_e   op_i,
  input  md_pkg::md_sign_t sign_mode_i,
  input  md_pkg::md_word_t op_a_i,
  input  md_pkg::md_word_t op_b_i,
  output md_pkg::md_word_t result_o,
  output logic             valid_o,
  output logic             busy_o
);

  import md_pkg::*;

  md_op_e   op;
  md_sign_t sign_mode;
  md_word_t op_a;
  md_word_t op_b;
  logic     mult_go;
  logic     div_go;
  logic     accept;
  logic     mult_done;
  logic     div_done;
  md_word_t mult_res;
  md_word_t div_res;

  assign accept = mult_go | div_go;

  md_decode u_decode (
    .clk_i, .rst_ni, .start_i,
    .busy_i(busy_o), .op_i, .sign_mode_i, .op_a_i, .op_b_i,
    .op_o(op), .sign_mode_o(sign_mode), .op_a_o(op_a), .op_b_o(op_b),
    .mult_go_o(mult_go), .div_go_o(div_go)
  );

  md_mult u_mult (
    .clk_i, .rst_ni, .go_i(mult_go), .op_i(op), .sign_mode_i(sign_mode),
    .op_a_i(op_a), .op_b_i(op_b), .done_o(mult_done), .result_o(mult_res)
  );

  md_div u_div (
    .clk_i, .rst_ni, .go_i(div_go), .op_i(op), .sign_mode_i(sign_mode),
    .op_a_i(op_a), .op_b_i(op_b), .done_o(div_done), .result_o(div_res)
  );

  md_result u_result (
    .clk_i, .rst_ni, .accept_i(accept), .mult_done_i(mult_done),
    .div_done_i(div_done), .mult_res_i(mult_res), .div_res_i(div_res),
    .valid_o, .busy_o, .result_o
  );

endmodule

//--- sim/md_props.sv
// Protocol properties for the multiply/divide unit
// Bound into the top level to watch the valid strobe, busy and the result

`timescale 1ns/10ps

module md_props (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             start_i,
  input logic             valid_i,
  input logic             busy_i,
  input md_pkg::md_word_t result_i
);

  logic started_q;

  // Set by the first request after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q <= 1'b0;
    end else if (start_i) begin
      started_q <= 1'b1;
    end
  end

  a_valid_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |=> !valid_i) else $error("valid_o stayed high for two cycles");

  a_busy_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |=> !busy_i) else $error("busy_o did not fall after valid_o");

  a_busy_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(busy_i) |-> $past(valid_i)) else $error("busy_o fell without valid_o");

  a_busy_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(busy_i) |-> $past(start_i)) else $error("busy_o rose without a start");

  a_valid_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> busy_i) else $error("valid_o outside a busy period");

  // Shortest path is the zero divisor at three cycles
  a_min_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(busy_i) |-> !valid_i ##1 !valid_i ##1 !valid_i)
    else $error("valid_o came too early after a start");

  a_result_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$stable(result_i) |-> valid_i) else $error("result_o changed without valid_o");

  a_idle_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !started_q |-> !valid_i && !busy_i)
    else $error("valid_o or busy_o high before the first start");

endmodule

bind md_top md_props u_props (
  .clk_i,
  .rst_ni,
  .start_i,
  .valid_i(valid_o),
  .busy_i(busy_o),
  .result_i(result_o)
);

//--- sim/md_tb.sv
// Testbench for the multiply/divide unit
// Directed and random MUL, MULH, DIV and REM requests checked against a
// reference model built from the RISC-V rules, with fixed latencies

`timescale 1ns/10ps

module md_tb;

  import md_pkg::*;

  localparam int unsigned SEED = 59;
  localparam int RAND_OPS = 24;
  localparam int TIMEOUT  = 64;

  logic     clk_i;
  logic     rst_ni;
  logic     start_i;
  md_op_e   op_i;
  md_sign_t sign_mode_i;
  md_word_t op_a_i;
  md_word_t op_b_i;
  md_word_t result_o;
  logic     valid_o;
  logic     busy_o;
  int       errors;
  int       timeouts;
  int       checks;

  md_top DUT (.*);

  always #2 clk_i = ~clk_i;

  // Operands are widened to 64 bits by their sign-mode bits first
  function automatic md_word_t ref_result(md_op_e op, md_sign_t sm, md_word_t a,
                                          md_word_t b);
    longint ea;
    longint eb;
    longint full;
    ea   = sm[0] ? longint'($signed(a)) : longint'(a);
    eb   = sm[1] ? longint'($signed(b)) : longint'(b);
    full = ea * eb;
    if (op == MD_OP_MULH) return full[63:32];
    if (op == MD_OP_MULL) return full[31:0];
    if (b == '0) return (op == MD_OP_DIV) ? '1 : a;
    // Min by minus one fits in 64 bits and wraps back to min
    full = (op == MD_OP_DIV) ? ea / eb : ea % eb;
    return full[31:0];
  endfunction

  function automatic int expected_latency(md_op_e op, md_word_t b);
    if (op == MD_OP_MULL) return 5;
    if (op == MD_OP_MULH) return 6;
    return (b == '0) ? 3 : 37;
  endfunction

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy_o && cycles < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (busy_o) begin
      $display("Timeout: busy_o stayed high for %0d cycles", TIMEOUT);
      timeouts++;
    end
  endtask

  // Latency counts edges from the one sampling start_i to the first valid
  task automatic run_op(input string name, input md_op_e op, input md_sign_t sm,
                        input md_word_t a, input md_word_t b, input bit poke);
    md_word_t exp_res;
    int       exp_lat;
    int       cycles;
    exp_res = ref_result(op, sm, a, b);
    exp_lat = expected_latency(op, b);
    wait_idle();
    start_i     = 1'b1;
    op_i        = op;
    sign_mode_i = sm;
    op_a_i      = a;
    op_b_i      = b;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
    cycles  = 0;
    while (!valid_o && cycles < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      cycles++;
      // Second request while busy, with other operands
      start_i = poke && (cycles == 2);
      op_a_i  = poke ? ~a : a;
    end
    start_i = 1'b0;
    if (!valid_o) begin
      $display("Timeout: %s got no valid_o within %0d cycles", name, TIMEOUT);
      timeouts++;
    end else begin
      checks++;
      assert (cycles == exp_lat) else begin
        $display("** Error %s latency: expected %0d, actual %0d", name, exp_lat, cycles);
        errors++;
      end
      assert (result_o == exp_res) else begin
        $display("** Error %s a=%h b=%h: expected %h, actual %h", name, a, b, exp_res,
                 result_o);
        errors++;
      end
    end
  endtask

  initial begin
    md_sign_t sm;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    start_i     = 1'b0;
    op_i        = MD_OP_MULL;
    sign_mode_i = '0;
    op_a_i      = '0;
    op_b_i      = '0;
    errors      = 0;
    timeouts    = 0;
    checks      = 0;
    void'($urandom(SEED));
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;

    run_op("mul", MD_OP_MULL, 2'b00, 32'h0000_0000, 32'hffff_ffff, 1'b0);
    run_op("mul", MD_OP_MULL, 2'b11, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    run_op("mul", MD_OP_MULL, 2'b00, 32'h1234_5678, 32'h9abc_def0, 1'b0);
    for (int i = 0; i < RAND_OPS; i++) begin
      run_op("mul", MD_OP_MULL, md_sign_t'($urandom()), $urandom(), $urandom(), 1'b0);
    end

    // All four sign modes of the high word
    for (int m = 0; m < 4; m++) begin
      sm = md_sign_t'(m);
      run_op("mulh", MD_OP_MULH, sm, 32'h8000_0000, 32'hffff_ffff, 1'b0);
      run_op("mulh", MD_OP_MULH, sm, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
      run_op("mulh", MD_OP_MULH, sm, 32'h7fff_ffff, 32'h8000_0000, 1'b0);
      for (int i = 0; i < RAND_OPS; i++) begin
        run_op("mulh", MD_OP_MULH, sm, $urandom(), $urandom(), 1'b0);
      end
    end

    // Unsigned then signed division
    for (int m = 0; m < 4; m += 3) begin
      sm = md_sign_t'(m);
      run_op("div", MD_OP_DIV, sm, 32'h8000_0000, 32'hffff_ffff, 1'b0);
      run_op("rem", MD_OP_REM, sm, 32'h8000_0000, 32'hffff_ffff, 1'b0);
      run_op("div", MD_OP_DIV, sm, 32'hffff_fff9, 32'h0000_0002, 1'b0);
      run_op("rem", MD_OP_REM, sm, 32'h0000_0007, 32'hffff_fffe, 1'b0);
      run_op("rem", MD_OP_REM, sm, 32'hffff_fff9, 32'hffff_fffe, 1'b1);
      for (int i = 0; i < RAND_OPS; i++) begin
        run_op("div", MD_OP_DIV, sm, $urandom(), $urandom() >> $urandom_range(31, 0),
               i == 0);
        run_op("rem", MD_OP_REM, sm, $urandom(), $urandom() >> $urandom_range(31, 0),
               1'b0);
      end
    end

    // Zero divisor shortcut
    run_op("div0", MD_OP_DIV, 2'b00, $urandom(), 32'h0, 1'b0);
    run_op("div0", MD_OP_DIV, 2'b11, 32'h8000_0000, 32'h0, 1'b0);
    run_op("rem0", MD_OP_REM, 2'b00, $urandom(), 32'h0, 1'b0);
    run_op("rem0", MD_OP_REM, 2'b11, 32'hffff_fff9, 32'h0, 1'b0);
    wait_idle();

    $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
hw/md_pkg.sv
hw/md_decode.sv
hw/md_mult.sv
hw/md_div.sv
hw/md_result.sv
hw/md_top.sv
sim/md_props.sv
sim/md_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module md_tb -f sources.f -o md_sim
	./obj_dir/md_sim | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
